// ==== rtl/rv_isa_pkg.sv ====
// RISC-V instruction encodings

package rv_isa_pkg;

  // --------------------------------------------------------------------------
  // Full-word encodings of the debug-relevant SYSTEM instructions
  // --------------------------------------------------------------------------

  localparam logic [31:0] EBREAK_OPCODE  = 32'h0010_0073;

  // Compressed form sits in the low half, upper half is zero
  localparam logic [31:0] CEBREAK_OPCODE = 32'h0000_9002;

  localparam logic [31:0] WFI_OPCODE     = 32'h1050_0073;
  localparam logic [31:0] DRET_OPCODE    = 32'h7b20_0073;

  // --------------------------------------------------------------------------
  // Classes reported for the instruction in write-back
  // --------------------------------------------------------------------------

  typedef enum logic [2:0] {
    CLASS_NONE    = 3'd0,
    CLASS_EBREAK  = 3'd1,
    CLASS_CEBREAK = 3'd2,
    CLASS_WFI     = 3'd3,
    CLASS_DRET    = 3'd4
  } instr_class_e;

  // --------------------------------------------------------------------------
  // CSR field codes
  // --------------------------------------------------------------------------

  // mtvec[1:0]
  localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'b00;
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

endpackage : rv_isa_pkg

// ==== rtl/dbg_mon_pkg.sv ====
// Debug monitor shared types

package dbg_mon_pkg;

  // --------------------------------------------------------------------------
  // Debug entry causes
  // --------------------------------------------------------------------------

  // Same coding as dcsr.cause
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  // --------------------------------------------------------------------------
  // Controller states as seen from outside the core
  // --------------------------------------------------------------------------

  typedef enum logic [2:0] {
    CTRL_RESET       = 3'd0,
    CTRL_BOOT_SET    = 3'd1,
    CTRL_FUNCTIONAL  = 3'd2,
    CTRL_DEBUG_TAKEN = 3'd3,
    CTRL_SLEEP       = 3'd4
  } ctrl_state_e;

  // Only reset, boot_set, functional and debug_taken
  // steer the trackers; sleep is reported but not acted on

endpackage : dbg_mon_pkg

// ==== rtl/wb_instr_classifier.sv ====
// Write-back instruction classifier

`timescale 1ns/1ps

module wb_instr_classifier #(
  parameter int NUM_IRQ = 32
) (
  input  logic                     wb_valid_i,
  input  logic [31:0]              wb_instr_i,
  input  logic                     wb_err_i,
  input  logic                     wb_access_ok_i,
  input  logic                     trigger_hit_i,
  input  logic [NUM_IRQ-1:0]       irq_i,
  input  logic [NUM_IRQ-1:0]       mie_i,
  output rv_isa_pkg::instr_class_e instr_class_o,
  output logic                     trigger_match_o,
  output logic                     pending_irq_o
);

  // Instruction actually retires: valid, no bus error and access allowed
  logic retire_ok;

  assign retire_ok = wb_valid_i && !wb_err_i && wb_access_ok_i;

  // --------------------------------------------------------------------------
  // Opcode match
  // --------------------------------------------------------------------------

  always_comb begin
    instr_class_o = rv_isa_pkg::CLASS_NONE;
    if (retire_ok) begin
      case (wb_instr_i)
        rv_isa_pkg::EBREAK_OPCODE: begin
          instr_class_o = rv_isa_pkg::CLASS_EBREAK;
        end
        rv_isa_pkg::CEBREAK_OPCODE: begin
          instr_class_o = rv_isa_pkg::CLASS_CEBREAK;
        end
        rv_isa_pkg::WFI_OPCODE: begin
          instr_class_o = rv_isa_pkg::CLASS_WFI;
        end
        rv_isa_pkg::DRET_OPCODE: begin
          instr_class_o = rv_isa_pkg::CLASS_DRET;
        end
        default: begin
          instr_class_o = rv_isa_pkg::CLASS_NONE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Trigger and interrupt qualifiers
  // --------------------------------------------------------------------------

  // Trigger only counts when the hit is on a valid write-back slot
  assign trigger_match_o = trigger_hit_i && wb_valid_i;

  // Any interrupt that is both pending and enabled in mie
  assign pending_irq_o = |(irq_i & mie_i);

endmodule : wb_instr_classifier

// ==== rtl/debug_cause_tracker.sv ====
// Expected debug cause tracker

`timescale 1ns/1ps

module debug_cause_tracker (
  input  logic                     cov_assert_if,
  input  logic                     rst_n_i,
  input  logic                     debug_mode_i,
  input  rv_isa_pkg::instr_class_e instr_class_i,
  input  logic                     trigger_match_i,
  input  logic                     dcsr_ebreakm_i,
  input  logic                     dcsr_step_i,
  input  logic                     debug_req_i,
  input  logic                     debug_req_q_i,
  input  dbg_mon_pkg::ctrl_state_e ctrl_state_i,
  output dbg_mon_pkg::dbg_cause_e  exp_cause_o
);

  dbg_mon_pkg::dbg_cause_e exp_cause_q;
  logic                    is_any_ebreak;
  logic                    is_functional;
  logic                    step_allowed;

  assign is_any_ebreak = (instr_class_i == rv_isa_pkg::CLASS_EBREAK) ||
                         (instr_class_i == rv_isa_pkg::CLASS_CEBREAK);

  assign is_functional = (ctrl_state_i == dbg_mon_pkg::CTRL_FUNCTIONAL);

  // Step does not displace a stronger cause that is still waiting
  assign step_allowed = (exp_cause_q == dbg_mon_pkg::CAUSE_NONE) ||
                        (exp_cause_q == dbg_mon_pkg::CAUSE_STEP);

  // --------------------------------------------------------------------------
  // Priority update, frozen while in debug mode
  // --------------------------------------------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      exp_cause_q <= dbg_mon_pkg::CAUSE_NONE;
    end else if (!debug_mode_i) begin
      if (trigger_match_i) begin
        exp_cause_q <= dbg_mon_pkg::CAUSE_TRIGGER;
      end else if (dcsr_ebreakm_i && is_any_ebreak) begin
        exp_cause_q <= dbg_mon_pkg::CAUSE_EBREAK;
      end else if ((debug_req_i || debug_req_q_i) && is_functional) begin
        exp_cause_q <= dbg_mon_pkg::CAUSE_HALTREQ;
      end else if (dcsr_step_i && step_allowed) begin
        exp_cause_q <= dbg_mon_pkg::CAUSE_STEP;
      end else if (is_functional) begin
        // Nothing pending while running normally
        exp_cause_q <= dbg_mon_pkg::CAUSE_NONE;
      end
    end
  end

  assign exp_cause_o = exp_cause_q;

endmodule : debug_cause_tracker

// ==== rtl/dpc_predictor.sv ====
// Expected dpc predictor

`timescale 1ns/1ps

module dpc_predictor #(
  parameter int XLEN = 32
) (
  input  logic                     cov_assert_if,
  input  logic                     rst_n_i,
  input  dbg_mon_pkg::ctrl_state_e ctrl_state_i,
  input  logic [XLEN-1:0]          boot_addr_i,
  input  logic                     retire_valid_i,
  input  logic [XLEN-1:0]          retire_pc_i,
  input  logic [XLEN-1:0]          retire_pc_next_i,
  input  logic                     wb_valid_i,
  input  logic [XLEN-1:0]          wb_pc_i,
  input  logic                     trigger_hit_i,
  input  logic                     tdata1_timing_i,
  input  logic                     irq_ack_i,
  input  logic [4:0]               irq_id_i,
  input  logic [XLEN-1:0]          mtvec_i,
  input  dbg_mon_pkg::dbg_cause_e  exp_cause_i,
  input  logic                     debug_mode_i,
  input  logic                     started_decoding_i,
  output logic [XLEN-1:0]          exp_dpc_o
);

  logic [XLEN-1:0] dpc_q;
  logic [XLEN-1:0] dpc_d;
  logic [XLEN-1:0] mtvec_base;
  logic [XLEN-1:0] irq_offset;
  logic            cause_at_pc;

  assign mtvec_base = {mtvec_i[XLEN-1:2], 2'b00};

  // Vector table entries are one word apart
  assign irq_offset = {{(XLEN-7){1'b0}}, irq_id_i, 2'b00};

  // Trigger and ebreak entries save the pc of the instruction itself
  assign cause_at_pc = !started_decoding_i &&
                       ((exp_cause_i == dbg_mon_pkg::CAUSE_TRIGGER) ||
                        (exp_cause_i == dbg_mon_pkg::CAUSE_EBREAK));

  // --------------------------------------------------------------------------
  // Next-value selection, later checks override earlier ones
  // --------------------------------------------------------------------------

  always_comb begin
    dpc_d = dpc_q;

    if (ctrl_state_i == dbg_mon_pkg::CTRL_BOOT_SET) begin
      dpc_d = {boot_addr_i[XLEN-1:2], 2'b00};
    end

    if (retire_valid_i) begin
      dpc_d = cause_at_pc ? retire_pc_i : retire_pc_next_i;
    end

    // Trigger that fires before execution
    if (trigger_hit_i && !tdata1_timing_i && wb_valid_i) begin
      dpc_d = wb_pc_i;
    end

    if (irq_ack_i) begin
      case (mtvec_i[1:0])
        rv_isa_pkg::MTVEC_MODE_DIRECT:   dpc_d = mtvec_base;
        rv_isa_pkg::MTVEC_MODE_VECTORED: dpc_d = mtvec_base + irq_offset;
        default:                         dpc_d = dpc_d;
      endcase
    end

    // Debug code is running, keep the saved value
    if (debug_mode_i && started_decoding_i) begin
      dpc_d = dpc_q;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      dpc_q <= '0;
    end else begin
      dpc_q <= dpc_d;
    end
  end

  assign exp_dpc_o = dpc_q;

endmodule : dpc_predictor

// ==== rtl/wfi_sleep_tracker.sv ====
// WFI sleep tracker

`timescale 1ns/1ps

module wfi_sleep_tracker (
  input  logic                     cov_assert_if,
  input  logic                     rst_n_i,
  input  rv_isa_pkg::instr_class_e instr_class_i,
  input  logic                     pending_debug_i,
  input  logic                     debug_mode_i,
  input  logic                     dcsr_step_i,
  input  logic                     pending_irq_i,
  input  logic                     debug_req_i,
  output logic                     in_wfi_o
);

  logic in_wfi_q;
  logic wfi_enter;
  logic wfi_wake;

  // WFI only sleeps outside debug, without stepping and with no halt waiting
  assign wfi_enter = (instr_class_i == rv_isa_pkg::CLASS_WFI) &&
                     !pending_debug_i && !debug_mode_i && !dcsr_step_i;

  assign wfi_wake = pending_irq_i || debug_req_i;

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_wake) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_enter) begin
      in_wfi_q <= 1'b1;
    end
  end

  assign in_wfi_o = in_wfi_q;

endmodule : wfi_sleep_tracker

// ==== rtl/debug_entry_tracker.sv ====
// Debug entry capture

`timescale 1ns/1ps

module debug_entry_tracker #(
  parameter int XLEN = 32
) (
  input  logic                     cov_assert_if,
  input  logic                     rst_n_i,
  input  dbg_mon_pkg::ctrl_state_e ctrl_state_i,
  input  logic [XLEN-1:0]          dm_halt_addr_i,
  input  logic [XLEN-1:0]          tdata2_i,
  input  logic                     debug_mode_i,
  input  rv_isa_pkg::instr_class_e instr_class_i,
  input  logic                     wb_valid_i,
  input  logic                     id_valid_i,
  output logic [XLEN-1:0]          halt_addr_o,
  output logic [XLEN-1:0]          tdata2_at_entry_o,
  output logic                     started_decoding_o,
  output logic                     first_debug_ins_o
);

  logic [XLEN-1:0] halt_addr_q;
  logic [XLEN-1:0] tdata2_q;
  logic            entry_q;
  logic            started_q;
  logic            retired_q;
  logic            is_any_ebreak;

  assign is_any_ebreak = (instr_class_i == rv_isa_pkg::CLASS_EBREAK) ||
                         (instr_class_i == rv_isa_pkg::CLASS_CEBREAK);

  // --------------------------------------------------------------------------
  // Halt address and trigger address at entry
  // --------------------------------------------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      entry_q     <= 1'b0;
      halt_addr_q <= '0;
      tdata2_q    <= '0;
    end else begin
      if (!entry_q && (ctrl_state_i == dbg_mon_pkg::CTRL_DEBUG_TAKEN)) begin
        halt_addr_q <= {dm_halt_addr_i[XLEN-1:2], 2'b00};
        tdata2_q    <= tdata2_i;
        entry_q     <= 1'b1;
      end
      // An ebreak inside debug re-enters at the halt address and may recapture
      if (!debug_mode_i || is_any_ebreak) begin
        entry_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // First instruction of the debug session
  // --------------------------------------------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      started_q <= 1'b0;
      retired_q <= 1'b0;
    end else if (debug_mode_i) begin
      if (id_valid_i) begin
        started_q <= 1'b1;
      end
      // Only a retirement of debug code counts
      if (wb_valid_i && started_q) begin
        retired_q <= 1'b1;
      end
    end else begin
      started_q <= 1'b0;
      retired_q <= 1'b0;
    end
  end

  assign first_debug_ins_o = debug_mode_i && wb_valid_i && started_q && !retired_q;

  assign halt_addr_o        = halt_addr_q;
  assign tdata2_at_entry_o  = tdata2_q;
  assign started_decoding_o = started_q;

endmodule : debug_entry_tracker

// ==== rtl/debug_monitor.sv ====
// Debug entry reference monitor

`timescale 1ns/1ps

module debug_monitor #(
  parameter int XLEN    = 32,
  parameter int NUM_IRQ = 32
) (
  input  logic                     cov_assert_if,
  input  logic                     rst_n_i,
  // Write-back stage
  input  logic                     wb_valid_i,
  input  logic [31:0]              wb_instr_i,
  input  logic                     wb_err_i,
  input  logic                     wb_access_ok_i,
  input  logic [XLEN-1:0]          wb_pc_i,
  input  logic                     id_valid_i,
  input  logic                     retire_valid_i,
  input  logic [XLEN-1:0]          retire_pc_i,
  input  logic [XLEN-1:0]          retire_pc_next_i,
  // Debug controls and CSRs
  input  logic                     debug_mode_i,
  input  logic                     debug_req_i,
  input  logic                     debug_req_q_i,
  input  logic                     pending_debug_i,
  input  logic                     dcsr_ebreakm_i,
  input  logic                     dcsr_step_i,
  input  logic                     trigger_hit_i,
  input  logic                     tdata1_timing_i,
  input  logic [XLEN-1:0]          tdata2_i,
  input  logic [XLEN-1:0]          dm_halt_addr_i,
  input  dbg_mon_pkg::ctrl_state_e ctrl_state_i,
  input  logic [XLEN-1:0]          boot_addr_i,
  // Interrupts
  input  logic [NUM_IRQ-1:0]       irq_i,
  input  logic [NUM_IRQ-1:0]       mie_i,
  input  logic                     irq_ack_i,
  input  logic [4:0]               irq_id_i,
  input  logic [XLEN-1:0]          mtvec_i,
  // Predictions
  output rv_isa_pkg::instr_class_e instr_class_o,
  output dbg_mon_pkg::dbg_cause_e  exp_cause_o,
  output logic [XLEN-1:0]          exp_dpc_o,
  output logic                     in_wfi_o,
  output logic [XLEN-1:0]          halt_addr_o,
  output logic [XLEN-1:0]          tdata2_at_entry_o,
  output logic                     first_debug_ins_o
);

  logic trigger_match;
  logic pending_irq;
  logic started_decoding;

  wb_instr_classifier #(
    .NUM_IRQ (NUM_IRQ)
  ) u_classifier (
    .wb_valid_i      (wb_valid_i),
    .wb_instr_i      (wb_instr_i),
    .wb_err_i        (wb_err_i),
    .wb_access_ok_i  (wb_access_ok_i),
    .trigger_hit_i   (trigger_hit_i),
    .irq_i           (irq_i),
    .mie_i           (mie_i),
    .instr_class_o   (instr_class_o),
    .trigger_match_o (trigger_match),
    .pending_irq_o   (pending_irq)
  );

  debug_cause_tracker u_cause (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n_i),
    .debug_mode_i    (debug_mode_i),
    .instr_class_i   (instr_class_o),
    .trigger_match_i (trigger_match),
    .dcsr_ebreakm_i  (dcsr_ebreakm_i),
    .dcsr_step_i     (dcsr_step_i),
    .debug_req_i     (debug_req_i),
    .debug_req_q_i   (debug_req_q_i),
    .ctrl_state_i    (ctrl_state_i),
    .exp_cause_o     (exp_cause_o)
  );

  dpc_predictor #(
    .XLEN (XLEN)
  ) u_dpc (
    .cov_assert_if      (cov_assert_if),
    .rst_n_i            (rst_n_i),
    .ctrl_state_i       (ctrl_state_i),
    .boot_addr_i        (boot_addr_i),
    .retire_valid_i     (retire_valid_i),
    .retire_pc_i        (retire_pc_i),
    .retire_pc_next_i   (retire_pc_next_i),
    .wb_valid_i         (wb_valid_i),
    .wb_pc_i            (wb_pc_i),
    .trigger_hit_i      (trigger_hit_i),
    .tdata1_timing_i    (tdata1_timing_i),
    .irq_ack_i          (irq_ack_i),
    .irq_id_i           (irq_id_i),
    .mtvec_i            (mtvec_i),
    .exp_cause_i        (exp_cause_o),
    .debug_mode_i       (debug_mode_i),
    .started_decoding_i (started_decoding),
    .exp_dpc_o          (exp_dpc_o)
  );

  wfi_sleep_tracker u_wfi (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n_i),
    .instr_class_i   (instr_class_o),
    .pending_debug_i (pending_debug_i),
    .debug_mode_i    (debug_mode_i),
    .dcsr_step_i     (dcsr_step_i),
    .pending_irq_i   (pending_irq),
    .debug_req_i     (debug_req_i),
    .in_wfi_o        (in_wfi_o)
  );

  debug_entry_tracker #(
    .XLEN (XLEN)
  ) u_entry (
    .cov_assert_if      (cov_assert_if),
    .rst_n_i            (rst_n_i),
    .ctrl_state_i       (ctrl_state_i),
    .dm_halt_addr_i     (dm_halt_addr_i),
    .tdata2_i           (tdata2_i),
    .debug_mode_i       (debug_mode_i),
    .instr_class_i      (instr_class_o),
    .wb_valid_i         (wb_valid_i),
    .id_valid_i         (id_valid_i),
    .halt_addr_o        (halt_addr_o),
    .tdata2_at_entry_o  (tdata2_at_entry_o),
    .started_decoding_o (started_decoding),
    .first_debug_ins_o  (first_debug_ins_o)
  );

endmodule : debug_monitor

// ==== dv/debug_monitor_tb.sv ====
// Debug monitor testbench

`timescale 1ns/1ps

module debug_monitor_tb;

  localparam int XLEN         = 32;
  localparam int NUM_IRQ      = 32;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;

  // Watchdog limit is the sum of the per-test cycle budgets
  localparam int RESET_TEST_CYCLES = RESET_CYCLES + 2;
  localparam int CLASS_CYCLES      = 10;
  localparam int CAUSE_CYCLES      = 14;
  localparam int DPC_CYCLES        = 16;
  localparam int WFI_CYCLES        = 14;
  localparam int ENTRY_CYCLES      = 12;
  localparam int MARGIN_CYCLES     = 40;
  localparam int RUN_CYCLES        = RESET_TEST_CYCLES + CLASS_CYCLES + CAUSE_CYCLES +
                                     DPC_CYCLES + WFI_CYCLES + ENTRY_CYCLES + MARGIN_CYCLES;

  // Standard RISC-V encodings
  localparam logic [31:0] ENC_EBREAK  = 32'h0010_0073;
  localparam logic [31:0] ENC_CEBREAK = 32'h0000_9002;
  localparam logic [31:0] ENC_WFI     = 32'h1050_0073;
  localparam logic [31:0] ENC_DRET    = 32'h7b20_0073;
  localparam logic [31:0] ENC_NOP     = 32'h0000_0013;

  logic                     cov_assert_if;
  logic                     rst_n_i;
  logic                     wb_valid_i;
  logic [31:0]              wb_instr_i;
  logic                     wb_err_i;
  logic                     wb_access_ok_i;
  logic [XLEN-1:0]          wb_pc_i;
  logic                     id_valid_i;
  logic                     retire_valid_i;
  logic [XLEN-1:0]          retire_pc_i;
  logic [XLEN-1:0]          retire_pc_next_i;
  logic                     debug_mode_i;
  logic                     debug_req_i;
  logic                     debug_req_q_i;
  logic                     pending_debug_i;
  logic                     dcsr_ebreakm_i;
  logic                     dcsr_step_i;
  logic                     trigger_hit_i;
  logic                     tdata1_timing_i;
  logic [XLEN-1:0]          tdata2_i;
  logic [XLEN-1:0]          dm_halt_addr_i;
  dbg_mon_pkg::ctrl_state_e ctrl_state_i;
  logic [XLEN-1:0]          boot_addr_i;
  logic [NUM_IRQ-1:0]       irq_i;
  logic [NUM_IRQ-1:0]       mie_i;
  logic                     irq_ack_i;
  logic [4:0]               irq_id_i;
  logic [XLEN-1:0]          mtvec_i;
  rv_isa_pkg::instr_class_e instr_class_o;
  dbg_mon_pkg::dbg_cause_e  exp_cause_o;
  logic [XLEN-1:0]          exp_dpc_o;
  logic                     in_wfi_o;
  logic [XLEN-1:0]          halt_addr_o;
  logic [XLEN-1:0]          tdata2_at_entry_o;
  logic                     first_debug_ins_o;

  logic [31:0] lcg_state = 32'd66353;
  bit          failed    = 1'b0;

  debug_monitor #(
    .XLEN    (XLEN),
    .NUM_IRQ (NUM_IRQ)
  ) dut0 (.*);

  initial begin
    cov_assert_if = 1'b0;
    forever #(CLK_PERIOD / 2) cov_assert_if = ~cov_assert_if;
  end

  initial begin
    #(CLK_PERIOD * RUN_CYCLES);
    $display("Test failures found");
    $fatal(1, "Watchdog expired after %0d cycles, tests did not complete", RUN_CYCLES);
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Registered outputs are stable at the falling edge
  task automatic tick();
    @(posedge cov_assert_if);
    @(negedge cov_assert_if);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp_val,
                           input logic [63:0] got_val);
    assert (got_val === exp_val) else begin
      failed = 1'b1;
      $display("error: time %0t, signal %s, expected %0h, actual %0h",
               $time, name, exp_val, got_val);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic clear_inputs();
    wb_valid_i       = 1'b0;
    wb_instr_i       = ENC_NOP;
    wb_err_i         = 1'b0;
    wb_access_ok_i   = 1'b1;
    wb_pc_i          = '0;
    id_valid_i       = 1'b0;
    retire_valid_i   = 1'b0;
    retire_pc_i      = '0;
    retire_pc_next_i = '0;
    debug_mode_i     = 1'b0;
    debug_req_i      = 1'b0;
    debug_req_q_i    = 1'b0;
    pending_debug_i  = 1'b0;
    dcsr_ebreakm_i   = 1'b0;
    dcsr_step_i      = 1'b0;
    trigger_hit_i    = 1'b0;
    tdata1_timing_i  = 1'b0;
    tdata2_i         = '0;
    dm_halt_addr_i   = '0;
    boot_addr_i      = '0;
    irq_i            = '0;
    mie_i            = '0;
    irq_ack_i        = 1'b0;
    irq_id_i         = '0;
    mtvec_i          = '0;
  endtask

  task automatic classify_once(input logic [31:0] instr, input logic valid, input logic err,
                               input logic ok, input rv_isa_pkg::instr_class_e exp_class);
    wb_instr_i     = instr;
    wb_valid_i     = valid;
    wb_err_i       = err;
    wb_access_ok_i = ok;
    #1;
    expect_eq("instr_class_o", exp_class, instr_class_o);
    tick();
  endtask

  task automatic retire_wfi();
    clear_inputs();
    wb_valid_i = 1'b1;
    wb_instr_i = ENC_WFI;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic reset_values();
    rst_n_i      = 1'b0;
    ctrl_state_i = dbg_mon_pkg::CTRL_RESET;
    clear_inputs();
    repeat (RESET_CYCLES) @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    rst_n_i = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_NONE, exp_cause_o);
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    expect_eq("exp_dpc_o", '0, exp_dpc_o);
    expect_eq("halt_addr_o", '0, halt_addr_o);
    expect_eq("tdata2_at_entry_o", '0, tdata2_at_entry_o);
    expect_eq("first_debug_ins_o", 1'b0, first_debug_ins_o);
    expect_eq("instr_class_o", rv_isa_pkg::CLASS_NONE, instr_class_o);
  endtask

  task automatic classify_opcodes();
    logic [31:0] other;
    other      = next_rand();
    // OP major opcode never matches a SYSTEM or compressed encoding
    other[6:0] = 7'h33;
    ctrl_state_i = dbg_mon_pkg::CTRL_FUNCTIONAL;
    classify_once(ENC_EBREAK, 1'b1, 1'b0, 1'b1, rv_isa_pkg::CLASS_EBREAK);
    classify_once(ENC_CEBREAK, 1'b1, 1'b0, 1'b1, rv_isa_pkg::CLASS_CEBREAK);
    classify_once(ENC_WFI, 1'b1, 1'b0, 1'b1, rv_isa_pkg::CLASS_WFI);
    classify_once(ENC_DRET, 1'b1, 1'b0, 1'b1, rv_isa_pkg::CLASS_DRET);
    classify_once(other, 1'b1, 1'b0, 1'b1, rv_isa_pkg::CLASS_NONE);
    // Retirement qualifiers
    classify_once(ENC_EBREAK, 1'b0, 1'b0, 1'b1, rv_isa_pkg::CLASS_NONE);
    classify_once(ENC_EBREAK, 1'b1, 1'b1, 1'b1, rv_isa_pkg::CLASS_NONE);
    classify_once(ENC_EBREAK, 1'b1, 1'b0, 1'b0, rv_isa_pkg::CLASS_NONE);
    clear_inputs();
  endtask

  task automatic cause_priority();
    ctrl_state_i = dbg_mon_pkg::CTRL_FUNCTIONAL;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_NONE, exp_cause_o);
    dcsr_step_i = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_STEP, exp_cause_o);
    // All causes at once, then remove them from the top down
    trigger_hit_i  = 1'b1;
    wb_valid_i     = 1'b1;
    wb_instr_i     = ENC_EBREAK;
    dcsr_ebreakm_i = 1'b1;
    debug_req_i    = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_TRIGGER, exp_cause_o);
    trigger_hit_i = 1'b0;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_EBREAK, exp_cause_o);
    wb_valid_i = 1'b0;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_HALTREQ, exp_cause_o);
    debug_req_i   = 1'b0;
    debug_req_q_i = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_HALTREQ, exp_cause_o);
    // Step cannot replace haltreq, so the cause falls back to none first
    debug_req_q_i = 1'b0;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_NONE, exp_cause_o);
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_STEP, exp_cause_o);
    // Held while in debug mode
    debug_mode_i  = 1'b1;
    debug_req_i   = 1'b1;
    trigger_hit_i = 1'b1;
    wb_valid_i    = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_STEP, exp_cause_o);
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_STEP, exp_cause_o);
    clear_inputs();
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_NONE, exp_cause_o);
  endtask

  task automatic dpc_prediction();
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] expected;
    logic [31:0]     rnd;
    addr         = next_rand();
    ctrl_state_i = dbg_mon_pkg::CTRL_BOOT_SET;
    boot_addr_i  = addr;
    tick();
    expect_eq("exp_dpc_o", {addr[XLEN-1:2], 2'b00}, exp_dpc_o);
    ctrl_state_i     = dbg_mon_pkg::CTRL_FUNCTIONAL;
    pc               = next_rand();
    retire_valid_i   = 1'b1;
    retire_pc_i      = pc;
    retire_pc_next_i = pc + 4;
    tick();
    expect_eq("exp_dpc_o", pc + 4, exp_dpc_o);
    // Trigger after execution makes the next retirement save its own pc
    retire_valid_i  = 1'b0;
    trigger_hit_i   = 1'b1;
    tdata1_timing_i = 1'b1;
    wb_valid_i      = 1'b1;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_TRIGGER, exp_cause_o);
    clear_inputs();
    pc               = next_rand();
    retire_valid_i   = 1'b1;
    retire_pc_i      = pc;
    retire_pc_next_i = pc + 4;
    tick();
    expect_eq("exp_dpc_o", pc, exp_dpc_o);
    // Same for ebreak with ebreakm
    clear_inputs();
    dcsr_ebreakm_i = 1'b1;
    wb_valid_i     = 1'b1;
    wb_instr_i     = ENC_EBREAK;
    tick();
    expect_eq("exp_cause_o", dbg_mon_pkg::CAUSE_EBREAK, exp_cause_o);
    clear_inputs();
    pc               = next_rand();
    retire_valid_i   = 1'b1;
    retire_pc_i      = pc;
    retire_pc_next_i = pc + 4;
    tick();
    expect_eq("exp_dpc_o", pc, exp_dpc_o);
    // Trigger before execution takes the write-back pc
    pc               = next_rand();
    wb_pc_i          = pc;
    wb_valid_i       = 1'b1;
    trigger_hit_i    = 1'b1;
    retire_pc_next_i = next_rand();
    tick();
    expect_eq("exp_dpc_o", pc, exp_dpc_o);
    // Interrupt acknowledge in direct then vectored mtvec mode
    clear_inputs();
    addr       = next_rand();
    addr[1:0]  = 2'b00;
    rnd        = next_rand();
    mtvec_i    = addr;
    irq_ack_i  = 1'b1;
    irq_id_i   = rnd[4:0];
    tick();
    expect_eq("exp_dpc_o", addr, exp_dpc_o);
    addr      = next_rand();
    addr[1:0] = 2'b01;
    rnd       = next_rand();
    mtvec_i   = addr;
    irq_id_i  = rnd[4:0];
    expected  = {addr[XLEN-1:2], 2'b00} + 4 * rnd[4:0];
    tick();
    expect_eq("exp_dpc_o", expected, exp_dpc_o);
    // Frozen once debug code is decoding
    clear_inputs();
    debug_mode_i = 1'b1;
    id_valid_i   = 1'b1;
    tick();
    retire_valid_i   = 1'b1;
    retire_pc_next_i = next_rand();
    tick();
    expect_eq("exp_dpc_o", expected, exp_dpc_o);
    clear_inputs();
    tick();
  endtask

  task automatic wfi_tracking();
    irq_i[3] = 1'b1;
    mie_i[3] = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    retire_wfi();
    tick();
    expect_eq("in_wfi_o", 1'b1, in_wfi_o);
    // Pending but masked interrupt does not wake
    wb_valid_i = 1'b0;
    irq_i[5]   = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b1, in_wfi_o);
    mie_i[5] = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    retire_wfi();
    tick();
    expect_eq("in_wfi_o", 1'b1, in_wfi_o);
    wb_valid_i  = 1'b0;
    debug_req_i = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    retire_wfi();
    debug_mode_i = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    retire_wfi();
    dcsr_step_i = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    retire_wfi();
    pending_debug_i = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    // Wake and WFI in the same cycle
    retire_wfi();
    irq_i[0] = 1'b1;
    mie_i[0] = 1'b1;
    tick();
    expect_eq("in_wfi_o", 1'b0, in_wfi_o);
    clear_inputs();
  endtask

  task automatic debug_entry();
    logic [XLEN-1:0] halt;
    logic [XLEN-1:0] t2;
    clear_inputs();
    halt           = next_rand();
    t2             = next_rand();
    ctrl_state_i   = dbg_mon_pkg::CTRL_DEBUG_TAKEN;
    debug_mode_i   = 1'b1;
    dm_halt_addr_i = halt;
    tdata2_i       = t2;
    tick();
    expect_eq("halt_addr_o", {halt[XLEN-1:2], 2'b00}, halt_addr_o);
    expect_eq("tdata2_at_entry_o", t2, tdata2_at_entry_o);
    dm_halt_addr_i = next_rand();
    tdata2_i       = next_rand();
    tick();
    expect_eq("halt_addr_o", {halt[XLEN-1:2], 2'b00}, halt_addr_o);
    expect_eq("tdata2_at_entry_o", t2, tdata2_at_entry_o);
    // A write-back before decoding starts is not the first debug instruction
    ctrl_state_i = dbg_mon_pkg::CTRL_FUNCTIONAL;
    id_valid_i   = 1'b1;
    wb_valid_i   = 1'b1;
    #1;
    expect_eq("first_debug_ins_o", 1'b0, first_debug_ins_o);
    tick();
    expect_eq("first_debug_ins_o", 1'b1, first_debug_ins_o);
    tick();
    expect_eq("first_debug_ins_o", 1'b0, first_debug_ins_o);
    // A new session captures again
    clear_inputs();
    tick();
    halt           = next_rand();
    ctrl_state_i   = dbg_mon_pkg::CTRL_DEBUG_TAKEN;
    debug_mode_i   = 1'b1;
    dm_halt_addr_i = halt;
    tick();
    expect_eq("halt_addr_o", {halt[XLEN-1:2], 2'b00}, halt_addr_o);
    clear_inputs();
    ctrl_state_i = dbg_mon_pkg::CTRL_FUNCTIONAL;
    tick();
  endtask

  initial begin
    reset_values();
    classify_opcodes();
    cause_priority();
    dpc_prediction();
    wfi_tracking();
    debug_entry();
    if (!failed) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : debug_monitor_tb

// ==== sources.f ====
rtl/rv_isa_pkg.sv
rtl/dbg_mon_pkg.sv
rtl/wb_instr_classifier.sv
rtl/debug_cause_tracker.sv
rtl/dpc_predictor.sv
rtl/wfi_sleep_tracker.sv
rtl/debug_entry_tracker.sv
rtl/debug_monitor.sv
dv/debug_monitor_tb.sv
